//--- rtl/dmi_pkg.sv
// dmi_pkg holds the debug module interface widths, codes, request layout and register map
package dmi_pkg;

    localparam int ABITS = 7;                   // dmi address width

    // target timing
    localparam int DMI_LATENCY = 3;             // busy cycles per accepted request
    localparam int LAT_W = $clog2(DMI_LATENCY + 1);

    // scratch register window
    localparam logic [ABITS-1:0] DM_REG_BASE = 7'h04;
    localparam int DM_REG_COUNT = 12;
    localparam int DM_IDX_W = $clog2(DM_REG_COUNT);

    typedef enum logic [1:0] {
        dmi_op_nop   = 2'd0,
        dmi_op_read  = 2'd1,
        dmi_op_write = 2'd2
    } dmi_op_e;

    typedef enum logic [1:0] {
        dmi_stat_success = 2'd0,
        dmi_stat_failed  = 2'd2,
        dmi_stat_busy    = 2'd3
    } dmi_stat_e;

    // dmi scan word whose op field carries the status on capture
    typedef struct packed {
        logic [ABITS-1:0] addr;
        logic [31:0]      data;
        logic [1:0]       op;
    } dmi_scan_t;

    // request towards the debug module
    typedef struct packed {
        logic             valid;
        logic             write;
        logic [ABITS-1:0] addr;
        logic [31:0]      data;
    } dmi_req_t;

endpackage

//--- rtl/dmi_regfile.sv
// dmi_regfile is the debug module target with twelve scratch registers and a fixed busy window
`timescale 1ns/100ps

module dmi_regfile (
    input  logic              i_tck,
    input  logic              i_trst,
    input  dmi_pkg::dmi_req_t i_req,
    input  logic              i_hardreset,
    output logic [31:0]       o_resp_data,
    output logic              o_busy,
    output logic              o_error
);

    import dmi_pkg::*;

    logic [31:0]         regs [DM_REG_COUNT];
    logic [ABITS-1:0]    offset;
    logic [DM_IDX_W-1:0] idx;
    logic                hit;
    logic [LAT_W-1:0]    busy_cnt;

    // addresses below the base wrap to a large offset and miss
    assign offset = i_req.addr - DM_REG_BASE;
    assign hit = (offset < ABITS'(DM_REG_COUNT));
    assign idx = offset[DM_IDX_W-1:0];

    assign o_busy = (busy_cnt != '0);

    // register storage where a write lands on the accepting edge
    always_ff @(posedge i_tck) begin
        if (i_hardreset) begin
            for (int i = 0; i < DM_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_req.valid && i_req.write && hit) begin
            regs[idx] <= i_req.data;
        end
    end

    // busy counter and response
    always_ff @(posedge i_tck, posedge i_trst) begin
        if (i_trst) begin
            busy_cnt <= '0;
            o_error <= 1'b0;
            o_resp_data <= '0;
        end else if (i_hardreset) begin
            busy_cnt <= '0;
            o_error <= 1'b0;
            o_resp_data <= '0;
        end else if (i_req.valid) begin
            busy_cnt <= LAT_W'(DMI_LATENCY);
            o_error <= !hit;
            if (!hit) begin
                o_resp_data <= '0;              // unmapped reads as zero
            end else if (i_req.write) begin
                o_resp_data <= i_req.data;
            end else begin
                o_resp_data <= regs[idx];
            end
        end else if (o_busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    // the dtm holds off while the window is open
    a_no_req_when_busy: assert property (
        @(posedge i_tck) disable iff (i_trst)
        i_req.valid |-> !o_busy
    );

endmodule

//--- rtl/dtm_regs.sv
// dtm_regs implements the ir and dr shift paths of the debug transport and issues dmi requests
`timescale 1ns/100ps

module dtm_regs (
    input  logic                 i_tck,
    input  logic                 i_trst,
    input  logic                 i_tdi,
    input  jtag_pkg::tap_state_e i_state,
    input  logic [31:0]          i_dmi_resp_data,
    input  logic                 i_dmi_busy,
    input  logic                 i_dmi_error,
    output logic                 o_tdo,
    output dmi_pkg::dmi_req_t    o_dmi_req,
    output logic                 o_dmi_hardreset
);

    import jtag_pkg::*;
    import dmi_pkg::*;

    dr_word_u           dr_q;
    dr_word_u           dr_d;
    logic [DRLEN_W-1:0] len_q;          // active dr length in bits
    logic [DRLEN_W-1:0] len_d;
    logic [IRLEN-1:0]   ir_q;
    logic [ABITS-1:0]   dmi_addr_q;     // address of the last dmi scan
    dmi_stat_e          stat_q;         // sticky dmi status
    dmi_stat_e          cap_stat;
    logic               resp_new_q;     // response not yet reported in a capture
    logic               op_valid;
    logic               dmi_go;
    logic               dtmcs_upd;

    assign o_tdo = dr_q[0];

    // status to report in a dmi capture
    always_comb begin
        cap_stat = stat_q;
        if (stat_q == dmi_stat_success) begin
            if (i_dmi_busy) begin
                cap_stat = dmi_stat_busy;       // scan started inside the busy window
            end else if (resp_new_q && i_dmi_error) begin
                cap_stat = dmi_stat_failed;
            end
        end
    end

    // capture and shift of the shared shift register
    always_comb begin
        dtmcs_t           cs;
        logic [DRLEN-1:0] shifted;

        cs = '0;
        cs.version = 4'd1;
        cs.abits = 6'(ABITS);
        cs.dmistat = stat_q;

        // lsb leaves on tdo, tdi enters at the top of the active length
        shifted = {1'b0, dr_q[DRLEN-1:1]};
        shifted[len_q - 1'b1] = i_tdi;

        dr_d = dr_q;
        len_d = len_q;
        case (i_state)
            capture_dr: begin
                dr_d = '0;
                case (ir_q)
                    IR_IDCODE: begin
                        dr_d = DRLEN'(IDCODE_VALUE);
                        len_d = DRLEN_W'(32);
                    end
                    IR_DTMCS: begin
                        dr_d.dtmcs.cs = cs;
                        len_d = DRLEN_W'(32);
                    end
                    IR_DMI: begin
                        dr_d.dmi.addr = dmi_addr_q;
                        dr_d.dmi.data = i_dmi_resp_data;
                        dr_d.dmi.op = cap_stat;
                        len_d = DRLEN_W'(DRLEN);
                    end
                    default: begin
                        len_d = DRLEN_W'(1);    // bypass and unknown codes
                    end
                endcase
            end
            capture_ir: begin
                dr_d = DRLEN'(2'b01);
                len_d = DRLEN_W'(IRLEN);
            end
            shift_dr, shift_ir: begin
                dr_d = shifted;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge i_tck) begin
        dr_q <= dr_d;
        len_q <= len_d;
    end

    // ir and dmi address move on the falling edge
    always_ff @(negedge i_tck, posedge i_trst) begin
        if (i_trst) begin
            ir_q <= IR_IDCODE;
            dmi_addr_q <= '0;
        end else begin
            case (i_state)
                test_logic_reset: begin
                    ir_q <= IR_IDCODE;
                end
                update_ir: begin
                    ir_q <= dr_q[IRLEN-1:0];
                end
                update_dr: begin
                    if (ir_q == IR_DMI) begin
                        dmi_addr_q <= dr_q.dmi.addr;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign op_valid = (dr_q.dmi.op == dmi_op_read) || (dr_q.dmi.op == dmi_op_write);
    assign dmi_go = (i_state == update_dr) && (ir_q == IR_DMI) && op_valid
                    && (stat_q == dmi_stat_success);
    assign dtmcs_upd = (i_state == update_dr) && (ir_q == IR_DTMCS);

    always_comb begin
        o_dmi_req.valid = dmi_go && !i_dmi_busy;
        o_dmi_req.write = (dr_q.dmi.op == dmi_op_write);
        o_dmi_req.addr = dr_q.dmi.addr;
        o_dmi_req.data = dr_q.dmi.data;
    end

    assign o_dmi_hardreset = dtmcs_upd && dr_q.dtmcs.cs.dmihardreset;

    // sticky status and response tracking
    always_ff @(posedge i_tck, posedge i_trst) begin
        if (i_trst) begin
            stat_q <= dmi_stat_success;
            resp_new_q <= 1'b0;
        end else if (i_state == capture_dr && ir_q == IR_DMI) begin
            stat_q <= cap_stat;
            if (!i_dmi_busy) begin
                resp_new_q <= 1'b0;             // reported in this capture
            end
        end else if (dmi_go) begin
            if (i_dmi_busy) begin
                stat_q <= dmi_stat_busy;        // request dropped
            end else begin
                resp_new_q <= 1'b1;
            end
        end else if (dtmcs_upd) begin
            if (dr_q.dtmcs.cs.dmireset || dr_q.dtmcs.cs.dmihardreset) begin
                stat_q <= dmi_stat_success;
            end
            if (dr_q.dtmcs.cs.dmihardreset) begin
                resp_new_q <= 1'b0;
            end
        end
    end

    // an accepted request opens the busy window of the target
    a_req_busy: assert property (
        @(posedge i_tck) disable iff (i_trst)
        o_dmi_req.valid |=> i_dmi_busy
    );

    // hardreset is a single tck pulse
    a_hardreset_pulse: assert property (
        @(posedge i_tck) disable iff (i_trst)
        o_dmi_hardreset |=> !o_dmi_hardreset
    );

endmodule

//--- rtl/jtag_dtm_top.sv
// jtag_dtm_top joins the tap controller, the debug transport and the dmi register target
`timescale 1ns/100ps

module jtag_dtm_top (
    input  logic i_tck,
    input  logic i_trst,
    input  logic i_tms,
    input  logic i_tdi,
    output logic o_tdo
);

    import jtag_pkg::*;
    import dmi_pkg::*;

    tap_state_e  tap_state;
    dmi_req_t    dmi_req;
    logic        dmi_hardreset;
    logic [31:0] dmi_resp_data;
    logic        dmi_busy;
    logic        dmi_error;

    tap_fsm u_tap_fsm (
        .i_tck   (i_tck),
        .i_trst  (i_trst),
        .i_tms   (i_tms),
        .o_state (tap_state)
    );

    dtm_regs u_dtm_regs (
        .i_tck           (i_tck),
        .i_trst          (i_trst),
        .i_tdi           (i_tdi),
        .i_state         (tap_state),
        .i_dmi_resp_data (dmi_resp_data),
        .i_dmi_busy      (dmi_busy),
        .i_dmi_error     (dmi_error),
        .o_tdo           (o_tdo),
        .o_dmi_req       (dmi_req),
        .o_dmi_hardreset (dmi_hardreset)
    );

    dmi_regfile u_dmi_regfile (
        .i_tck       (i_tck),
        .i_trst      (i_trst),
        .i_req       (dmi_req),
        .i_hardreset (dmi_hardreset),
        .o_resp_data (dmi_resp_data),
        .o_busy      (dmi_busy),
        .o_error     (dmi_error)
    );

endmodule

//--- rtl/jtag_pkg.sv
// jtag_pkg holds the tap state encoding, instruction codes and dtm register layouts
package jtag_pkg;

    typedef enum logic [3:0] {
        test_logic_reset = 4'd0,
        run_test_idle    = 4'd1,
        select_dr_scan   = 4'd2,
        capture_dr       = 4'd3,
        shift_dr         = 4'd4,
        exit1_dr         = 4'd5,
        pause_dr         = 4'd6,
        exit2_dr         = 4'd7,
        update_dr        = 4'd8,
        select_ir_scan   = 4'd9,
        capture_ir       = 4'd10,
        shift_ir         = 4'd11,
        exit1_ir         = 4'd12,
        pause_ir         = 4'd13,
        exit2_ir         = 4'd14,
        update_ir        = 4'd15
    } tap_state_e;

    localparam int IRLEN = 5;

    localparam logic [IRLEN-1:0] IR_IDCODE = 5'h01;
    localparam logic [IRLEN-1:0] IR_DTMCS  = 5'h10;
    localparam logic [IRLEN-1:0] IR_DMI    = 5'h11;
    localparam logic [IRLEN-1:0] IR_BYPASS = 5'h1F;

    localparam logic [31:0] IDCODE_VALUE = 32'h10E31913;

    localparam int DRLEN = dmi_pkg::ABITS + 34;
    localparam int DRLEN_W = $clog2(DRLEN + 1);    // width of the active scan length

    typedef struct packed {
        logic [13:0]        padding;
        logic               dmihardreset;
        logic               dmireset;
        logic [3:0]         zero;
        dmi_pkg::dmi_stat_e dmistat;
        logic [5:0]         abits;
        logic [3:0]         version;
    } dtmcs_t;

    // one shift word read through the view that matches the current ir
    typedef union packed {
        dmi_pkg::dmi_scan_t dmi;
        struct packed {
            logic [DRLEN-33:0] pad;
            dtmcs_t            cs;
        } dtmcs;
    } dr_word_u;

endpackage

//--- rtl/tap_fsm.sv
// tap_fsm steps the sixteen ieee 1149.1 tap states on tms at every rising tck
`timescale 1ns/100ps

module tap_fsm (
    input  logic                 i_tck,
    input  logic                 i_trst,
    input  logic                 i_tms,
    output jtag_pkg::tap_state_e o_state
);

    import jtag_pkg::*;

    tap_state_e state_d;

    // next state table
    always_comb begin
        case (o_state)
            test_logic_reset: state_d = i_tms ? test_logic_reset : run_test_idle;
            run_test_idle:    state_d = i_tms ? select_dr_scan : run_test_idle;

            // data register column
            select_dr_scan:   state_d = i_tms ? select_ir_scan : capture_dr;
            capture_dr:       state_d = i_tms ? exit1_dr : shift_dr;
            shift_dr:         state_d = i_tms ? exit1_dr : shift_dr;
            exit1_dr:         state_d = i_tms ? update_dr : pause_dr;
            pause_dr:         state_d = i_tms ? exit2_dr : pause_dr;
            exit2_dr:         state_d = i_tms ? update_dr : shift_dr;
            update_dr:        state_d = i_tms ? select_dr_scan : run_test_idle;

            // instruction register column
            select_ir_scan:   state_d = i_tms ? test_logic_reset : capture_ir;
            capture_ir:       state_d = i_tms ? exit1_ir : shift_ir;
            shift_ir:         state_d = i_tms ? exit1_ir : shift_ir;
            exit1_ir:         state_d = i_tms ? update_ir : pause_ir;
            pause_ir:         state_d = i_tms ? exit2_ir : pause_ir;
            exit2_ir:         state_d = i_tms ? update_ir : shift_ir;
            update_ir:        state_d = i_tms ? select_dr_scan : run_test_idle;

            default:          state_d = test_logic_reset;
        endcase
    end

    always_ff @(posedge i_tck, posedge i_trst) begin
        if (i_trst) begin
            o_state <= test_logic_reset;
        end else begin
            o_state <= state_d;
        end
    end

    // five tms-high clocks reach reset from anywhere
    a_tms_reset: assert property (
        @(posedge i_tck) disable iff (i_trst)
        i_tms [*5] |=> (o_state == test_logic_reset)
    );

endmodule

//--- src.f
rtl/dmi_pkg.sv
rtl/jtag_pkg.sv
rtl/tap_fsm.sv
rtl/dtm_regs.sv
rtl/dmi_regfile.sv
rtl/jtag_dtm_top.sv
test/tb_jtag_dtm.sv

//--- test/tb_jtag_dtm.sv
// tb_jtag_dtm bit-bangs jtag scans into the debug transport and checks captures against a model
`timescale 1ns/100ps

module tb_jtag_dtm;

    import jtag_pkg::*;
    import dmi_pkg::*;

    // about 40 scans of up to 60 clocks, plus margin
    localparam int TIMEOUT_CYCLES = 40 * 60 + 1600;

    logic i_tck;
    logic i_trst;
    logic i_tms;
    logic i_tdi;
    logic o_tdo;

    // reference model state
    logic [31:0]      ref_regs [DM_REG_COUNT];
    logic [IRLEN-1:0] ref_ir;
    logic [1:0]       ref_stat;         // sticky status
    logic [ABITS-1:0] ref_addr;         // address of the last dmi scan
    logic [31:0]      ref_resp;
    logic             ref_error;
    logic             ref_resp_new;
    logic             ref_req_pending;  // last scan issued a request
    int               ref_idle;         // idle clocks since the last scan

    logic [DRLEN-1:0] got_q [$];
    logic [DRLEN-1:0] exp_q [$];
    string            tag_q [$];
    int               errors;
    int               checks;
    int               cycles;
    logic [ABITS-1:0] waddr [4];

    jtag_dtm_top dut (
        .i_tck  (i_tck),
        .i_trst (i_trst),
        .i_tms  (i_tms),
        .i_tdi  (i_tdi),
        .o_tdo  (o_tdo)
    );

    always #10 i_tck = ~i_tck;

    always @(posedge i_tck) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // compare process draining the scan results
    always @(negedge i_tck) begin
        while (got_q.size() > 0) begin
            logic [DRLEN-1:0] got;
            logic [DRLEN-1:0] exp;
            string            tag;
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            tag = tag_q.pop_front();
            checks++;
            assert (got === exp) else begin
                errors++;
                $display("MISMATCH at %0t: %s, got %h, expected %h", $time, tag, got, exp);
            end
        end
    end

    // capture sits two clocks after the scan starts and busy lasts DMI_LATENCY clocks
    function automatic logic busy_at_capture();
        return ref_req_pending && (ref_idle + 2 < DMI_LATENCY);
    endfunction

    function automatic logic [1:0] capture_status();
        if (ref_stat != dmi_stat_success) return ref_stat;
        if (busy_at_capture()) return dmi_stat_busy;
        if (ref_resp_new && ref_error) return dmi_stat_failed;
        return dmi_stat_success;
    endfunction

    // expected shifted-out word of a dr scan of n bits
    function automatic logic [DRLEN-1:0] expected_capture(input logic [IRLEN-1:0] ir,
                                                          input logic [DRLEN-1:0] din,
                                                          input int n);
        logic [DRLEN-1:0] word;
        logic [DRLEN-1:0] mask;
        case (ir)
            IR_IDCODE: word = DRLEN'(IDCODE_VALUE);
            IR_DTMCS:  word = DRLEN'({ref_stat, 6'(ABITS), 4'd1});
            IR_DMI:    word = {ref_addr, ref_resp, capture_status()};
            default:   word = din << 1;     // bypass delays by one bit
        endcase
        mask = (DRLEN'(1) << n) - 1'b1;
        return word & mask;
    endfunction

    // applies capture and update of a dr scan to the model
    task automatic update_model(input logic [DRLEN-1:0] din);
        logic             busy;
        logic [ABITS-1:0] offs;
        logic [1:0]       op;
        busy = busy_at_capture();
        if (ref_ir == IR_DMI) begin
            ref_stat = capture_status();
            if (!busy) ref_resp_new = 1'b0;
        end
        ref_req_pending = 1'b0;
        if (ref_ir == IR_DMI) begin
            ref_addr = din[DRLEN-1:34];
            op = din[1:0];
            if ((op == dmi_op_read || op == dmi_op_write) && ref_stat == dmi_stat_success) begin
                offs = ref_addr - DM_REG_BASE;
                ref_req_pending = 1'b1;
                ref_resp_new = 1'b1;
                ref_error = (offs >= DM_REG_COUNT);
                if (ref_error) begin
                    ref_resp = '0;
                end else if (op == dmi_op_write) begin
                    ref_regs[offs] = din[33:2];
                    ref_resp = din[33:2];
                end else begin
                    ref_resp = ref_regs[offs];
                end
            end
        end else if (ref_ir == IR_DTMCS) begin
            if (din[16] || din[17]) ref_stat = dmi_stat_success;
            if (din[17]) begin
                foreach (ref_regs[i]) ref_regs[i] = '0;
                ref_resp = '0;
                ref_error = 1'b0;
                ref_resp_new = 1'b0;
            end
        end
        ref_idle = 0;
    endtask

    task automatic drive(input logic tms, input logic tdi);
        @(negedge i_tck);
        i_tms = tms;
        i_tdi = tdi;
    endtask

    task automatic idle(input int k);
        repeat (k) drive(1'b0, 1'b0);
        ref_idle += k;
    endtask

    // full scan from run_test_idle back to run_test_idle with tdo read while tck is low
    task automatic shift_scan(input logic is_ir, input logic [DRLEN-1:0] din, input int n,
                              output logic [DRLEN-1:0] dout);
        dout = '0;
        drive(1'b1, 1'b0);                  // select_dr_scan
        if (is_ir) drive(1'b1, 1'b0);       // select_ir_scan
        drive(1'b0, 1'b0);                  // capture
        drive(1'b0, 1'b0);                  // shift
        for (int i = 0; i < n; i++) begin
            @(negedge i_tck);
            dout[i] = o_tdo;
            i_tdi = din[i];
            i_tms = (i == n - 1);
        end
        drive(1'b1, 1'b0);                  // update
        drive(1'b0, 1'b0);                  // back to idle
    endtask

    task automatic queue_result(input logic [DRLEN-1:0] got, input logic [DRLEN-1:0] exp,
                                input string tag);
        got_q.push_back(got);
        exp_q.push_back(exp);
        tag_q.push_back(tag);
    endtask

    task automatic ir_access(input logic [IRLEN-1:0] code);
        logic [DRLEN-1:0] got;
        shift_scan(1'b1, DRLEN'(code), IRLEN, got);
        queue_result(got, DRLEN'(5'b00001), "ir capture");
        ref_ir = code;
        ref_req_pending = 1'b0;
        ref_idle = 0;
    endtask

    task automatic dr_access(input logic [DRLEN-1:0] din, input int n, input string tag);
        logic [DRLEN-1:0] exp;
        logic [DRLEN-1:0] got;
        exp = expected_capture(ref_ir, din, n);
        shift_scan(1'b0, din, n, got);
        queue_result(got, exp, tag);
        update_model(din);
    endtask

    task automatic dmi_access(input logic [ABITS-1:0] addr, input logic [31:0] data,
                              input logic [1:0] op, input int k, input string tag);
        dr_access({addr, data, op}, DRLEN, tag);
        idle(k);
    endtask

    initial begin
        int unsigned seed_ret;
        seed_ret = $urandom(32'h465e);
        i_tck = 1'b0;
        i_trst = 1'b1;
        i_tms = 1'b1;
        i_tdi = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        foreach (ref_regs[i]) ref_regs[i] = '0;
        ref_ir = IR_IDCODE;
        ref_stat = dmi_stat_success;
        ref_addr = '0;
        ref_resp = '0;
        ref_error = 1'b0;
        ref_resp_new = 1'b0;
        ref_req_pending = 1'b0;
        ref_idle = 0;
        repeat (2) @(posedge i_tck);
        @(negedge i_tck);
        i_trst = 1'b0;
        idle(2);

        dr_access(DRLEN'($urandom), 32, "idcode after reset");
        ir_access(IR_BYPASS);
        dr_access(DRLEN'($urandom), 8, "bypass 8 bits");
        dr_access(DRLEN'($urandom), 20, "bypass 20 bits");
        ir_access(IR_DTMCS);
        dr_access('0, 32, "dtmcs fields");

        ir_access(IR_DMI);
        foreach (waddr[i]) begin
            waddr[i] = DM_REG_BASE + ABITS'($urandom % DM_REG_COUNT);
            dmi_access(waddr[i], $urandom, dmi_op_write, DMI_LATENCY, "dmi write");
        end
        foreach (waddr[i]) dmi_access(waddr[i], '0, dmi_op_read, DMI_LATENCY, "dmi read");
        dmi_access('0, '0, dmi_op_nop, DMI_LATENCY, "last read data");

        // back-to-back scan sets sticky busy and the next ones are dropped
        dmi_access(waddr[0], $urandom, dmi_op_write, 0, "write before busy");
        dmi_access(waddr[0], $urandom, dmi_op_write, DMI_LATENCY, "write during busy");
        dmi_access(waddr[0], '0, dmi_op_read, DMI_LATENCY, "scan with sticky busy");
        ir_access(IR_DTMCS);
        dr_access(DRLEN'(1) << 16, 32, "dtmcs dmireset after busy");
        ir_access(IR_DMI);
        dmi_access(waddr[0], '0, dmi_op_read, DMI_LATENCY, "read after dmireset");
        dmi_access('0, '0, dmi_op_nop, DMI_LATENCY, "register kept after busy");
        dmi_access(7'h7F, '0, dmi_op_read, DMI_LATENCY, "unmapped read");
        dmi_access('0, '0, dmi_op_nop, DMI_LATENCY, "unmapped status");
        dmi_access('0, '0, dmi_op_nop, DMI_LATENCY, "failed stays sticky");
        ir_access(IR_DTMCS);
        dr_access(DRLEN'(1) << 16, 32, "dtmcs dmireset after failed");

        // hard reset wipes the target
        ir_access(IR_DMI);
        dmi_access(waddr[1], $urandom, dmi_op_write, DMI_LATENCY, "write before hardreset");
        dmi_access('0, '0, dmi_op_nop, DMI_LATENCY, "write response");
        ir_access(IR_DTMCS);
        dr_access(DRLEN'(1) << 17, 32, "dtmcs dmihardreset");
        ir_access(IR_DMI);
        dmi_access(waddr[1], '0, dmi_op_read, DMI_LATENCY, "read after hardreset");
        dmi_access('0, '0, dmi_op_nop, DMI_LATENCY, "cleared register");
        idle(2);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
